//--- src/test_cpu_consts.svh
////////////////////////////////////////////////////////////
// test cpu widths
// microword, register, bus and pattern-store field sizes
////////////////////////////////////////////////////////////

`ifndef TEST_CPU_CONSTS_SVH
`define TEST_CPU_CONSTS_SVH

`define TC_UWORD_W 48   // full microword
`define TC_PC_W    8    // program counter
`define TC_DATA_W  32   // registers and bus data
`define TC_ADDR_W  22   // bus word address
`define TC_NEXT_W  6    // branch target field

`define TC_OP_W    4    // opcode field
`define TC_SEL_W   3    // register select field

`define TC_PAT_W   8    // pattern store index
`define TC_WAIT_W  5    // wait microop counter

`endif

//--- src/test_cpu_pkg.sv
////////////////////////////////////////////////////////////
// test cpu types
// opcodes, register selects, bus states and microword
////////////////////////////////////////////////////////////

`default_nettype none

`include "test_cpu_consts.svh"

package test_cpu_pkg;

   typedef enum logic [`TC_OP_W-1:0] {
      op_nop   = 4'd0,
      op_write = 4'd1,
      op_read  = 4'd2,
      op_add   = 4'd3,
      op_sub   = 4'd4,
      op_tst   = 4'd5,
      op_cmp   = 4'd6,
      op_jmp   = 4'd7,
      op_done  = 4'd8,
      op_wait  = 4'd9,
      op_fault = 4'd15
   } uop_e;

   typedef enum logic [`TC_SEL_W-1:0] {
      sel_none    = 3'd0,
      sel_a       = 3'd1,
      sel_b       = 3'd2,
      sel_c       = 3'd3,
      sel_d       = 3'd4,
      sel_imm     = 3'd5,
      sel_pattern = 3'd7   // expected word from pattern store
   } reg_sel_e;

   typedef enum logic [1:0] {
      bus_idle = 2'd0,
      bus_req  = 2'd1,
      bus_wait = 2'd2,
      bus_done = 2'd3
   } bus_state_e;

   typedef struct packed {
      uop_e                  op;
      reg_sel_e              dst;
      reg_sel_e              src;
      logic [`TC_NEXT_W-1:0] next;   // branch target
      logic [`TC_DATA_W-1:0] imm;
   } uword_t;

   typedef struct packed {
      logic rd;
      logic wr;
   } bus_cmd_t;

endpackage

`default_nettype wire

//--- src/ucode_rom.sv
////////////////////////////////////////////////////////////
// microprogram store
// fills the buffer, starts the transfer, polls status,
// then checks the buffer against the pattern store
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "test_cpu_consts.svh"

module ucode_rom
(
   input  wire                  clk,
   input  wire                  reset,
   input  wire [`TC_PC_W-1:0]   addr,
   output test_cpu_pkg::uword_t uword
);

   import test_cpu_pkg::*;

   always_ff @(posedge clk)
   begin
      if (reset)
         uword <= {`TC_UWORD_W{1'b0}};   // nop
      else
         case (addr)
            // fill buffer with the pattern
            8'h00: uword <= '{op_add,   sel_a,    sel_none,    6'h00, 32'h0001_1000};
            8'h01: uword <= '{op_add,   sel_b,    sel_none,    6'h00, 32'h0};
            8'h02: uword <= '{op_add,   sel_d,    sel_pattern, 6'h00, 32'h0};
            8'h03: uword <= '{op_write, sel_none, sel_none,    6'h00, 32'h0};
            8'h04: uword <= '{op_add,   sel_a,    sel_a,       6'h00, 32'h1};
            8'h05: uword <= '{op_add,   sel_b,    sel_b,       6'h00, 32'h1};
            8'h06: uword <= '{op_cmp,   sel_b,    sel_imm,     6'h08, 32'h100};
            8'h07: uword <= '{op_jmp,   sel_none, sel_none,    6'h02, 32'h0};

            // device registers
            8'h08: uword <= '{op_add,   sel_a,    sel_none,    6'h00, 32'o17377776};
            8'h09: uword <= '{op_add,   sel_d,    sel_none,    6'h00, 32'h0001_1000};
            8'h0a: uword <= '{op_write, sel_none, sel_none,    6'h00, 32'h0};   // mem addr
            8'h0b: uword <= '{op_add,   sel_a,    sel_none,    6'h00, 32'o17377775};
            8'h0c: uword <= '{op_add,   sel_d,    sel_none,    6'h00, 32'h0001_0100};
            8'h0d: uword <= '{op_write, sel_none, sel_none,    6'h00, 32'h0};   // disk addr
            8'h0e: uword <= '{op_add,   sel_a,    sel_none,    6'h00, 32'o17377774};
            8'h0f: uword <= '{op_add,   sel_d,    sel_none,    6'h00, 32'o11};
            8'h10: uword <= '{op_write, sel_none, sel_none,    6'h00, 32'h0};   // command
            8'h11: uword <= '{op_add,   sel_a,    sel_none,    6'h00, 32'o17377777};
            8'h12: uword <= '{op_add,   sel_d,    sel_none,    6'h00, 32'h0};
            8'h13: uword <= '{op_write, sel_none, sel_none,    6'h00, 32'h0};   // go

            // poll status until bit 0 clears
            8'h14: uword <= '{op_wait,  sel_none, sel_none,    6'h00, 32'h0};
            8'h15: uword <= '{op_add,   sel_a,    sel_none,    6'h00, 32'o17377770};
            8'h16: uword <= '{op_read,  sel_none, sel_none,    6'h00, 32'h0};
            8'h17: uword <= '{op_tst,   sel_d,    sel_imm,     6'h19, 32'h1};
            8'h18: uword <= '{op_jmp,   sel_none, sel_none,    6'h14, 32'h0};

            // read back and compare
            8'h19: uword <= '{op_add,   sel_a,    sel_none,    6'h00, 32'h0001_1000};
            8'h1a: uword <= '{op_add,   sel_b,    sel_none,    6'h00, 32'h0};
            8'h1b: uword <= '{op_read,  sel_none, sel_none,    6'h00, 32'h0};
            8'h1c: uword <= '{op_cmp,   sel_d,    sel_pattern, 6'h1e, 32'h0};
            8'h1d: uword <= '{op_fault, sel_none, sel_none,    6'h1d, 32'h0};   // halt
            8'h1e: uword <= '{op_add,   sel_a,    sel_a,       6'h00, 32'h1};
            8'h1f: uword <= '{op_add,   sel_b,    sel_b,       6'h00, 32'h1};
            8'h20: uword <= '{op_cmp,   sel_b,    sel_imm,     6'h22, 32'h100};
            8'h21: uword <= '{op_jmp,   sel_none, sel_none,    6'h1b, 32'h0};
            8'h22: uword <= '{op_done,  sel_none, sel_none,    6'h22, 32'h0};   // halt

            default: uword <= '{op_jmp, sel_none, sel_none, 6'h00, 32'h0};
         endcase
   end

endmodule

`default_nettype wire

//--- src/pattern_rom.sv
////////////////////////////////////////////////////////////
// pattern store
// expected buffer word for each of the 256 buffer slots
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "test_cpu_consts.svh"

module pattern_rom
(
   input  wire                    clk,
   input  wire                    reset,
   input  wire  [`TC_PAT_W-1:0]   index,
   output logic [`TC_DATA_W-1:0]  expected
);

   // i * 0x01010101 with the upper half inverted
   function automatic logic [`TC_DATA_W-1:0] pattern_word(input logic [`TC_PAT_W-1:0] i);
      logic [`TC_DATA_W-1:0] w;
      w = {(`TC_DATA_W/`TC_PAT_W){i}};
      return {~w[`TC_DATA_W-1:`TC_DATA_W/2], w[`TC_DATA_W/2-1:0]};
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
         expected <= '0;
      else
         expected <= pattern_word(index);
   end

endmodule

`default_nettype wire

//--- src/bus_requester.sv
////////////////////////////////////////////////////////////
// bus requester
// runs the memrq/memack handshake for read and write microops
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module bus_requester
(
   input  wire                    clk,
   input  wire                    reset,
   input  wire test_cpu_pkg::bus_cmd_t cmd,
   input  wire                    memack,
   output logic                   memrq,
   output logic                   memwr,
   output logic                   mem_done
);

   import test_cpu_pkg::*;

   bus_state_e state;
   bus_state_e state_next;

   always_comb
   begin
      state_next = state;
      case (state)
         bus_idle: if (cmd.rd || cmd.wr) state_next = bus_req;
         bus_req:  if (memack) state_next = bus_wait;
         bus_wait: if (!memack) state_next = bus_done;   // slave let go
         bus_done: state_next = bus_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= bus_idle;
         memrq <= 1'b0;
         memwr <= 1'b0;
      end
      else
      begin
         state <= state_next;
         memrq <= state_next == bus_req;   // tracks the req state exactly
         memwr <= state_next == bus_req && cmd.wr;
      end
   end

   assign mem_done = state == bus_done;

endmodule

`default_nettype wire

//--- src/ucode_sequencer.sv
////////////////////////////////////////////////////////////
// microcode sequencer
// program counter, branches, registers a-d, add/sub unit
// and the stall logic for wait and bus microops
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "test_cpu_consts.svh"

module ucode_sequencer
(
   input  wire                         clk,
   input  wire                         reset,
   input  wire                         start,
   input  wire test_cpu_pkg::uword_t   uword,
   input  wire  [`TC_DATA_W-1:0]       expected,
   input  wire                         mem_done,
   input  wire                         memdone,
   input  wire  [`TC_DATA_W-1:0]       rdata,
   output logic [`TC_PC_W-1:0]         next_pc,
   output logic [`TC_ADDR_W-1:0]       addr,
   output logic [`TC_DATA_W-1:0]       wdata,
   output test_cpu_pkg::bus_cmd_t      cmd,
   output logic                        done,
   output logic                        fault
);

   import test_cpu_pkg::*;

   logic [`TC_PC_W-1:0]   pc;
   logic [`TC_PC_W-1:0]   npc;
   logic [`TC_DATA_W-1:0] a, b, c, d;
   logic [`TC_DATA_W-1:0] src_val;
   logic [`TC_DATA_W-1:0] dst_val;
   logic [`TC_DATA_W-1:0] alu_out;
   logic [`TC_WAIT_W-1:0] wait_count;
   logic                  wait_done;
   logic                  stall;
   logic                  load_pc;

   always_comb
   begin
      case (uword.src)
         sel_a:       src_val = a;
         sel_b:       src_val = b;
         sel_c:       src_val = c;
         sel_d:       src_val = d;
         sel_imm:     src_val = uword.imm;
         sel_pattern: src_val = expected;
         default:     src_val = '0;
      endcase
   end

   always_comb
   begin
      case (uword.dst)
         sel_a:   dst_val = a;
         sel_b:   dst_val = b;
         sel_c:   dst_val = c;
         sel_d:   dst_val = d;
         default: dst_val = '0;
      endcase
   end

   assign alu_out = (uword.op == op_sub) ? src_val - uword.imm : src_val + uword.imm;

   always_comb
   begin
      case (uword.op)
         op_tst:  load_pc = ~|(dst_val & src_val);   // no common bit
         op_cmp:  load_pc = dst_val == src_val;
         op_jmp, op_done, op_fault: load_pc = 1'b1;   // halts jump to self
         default: load_pc = 1'b0;
      endcase
   end

   assign wait_done = wait_count == '1;
   assign stall = !start
                  || (uword.op == op_wait && !wait_done)
                  || ((uword.op == op_read || uword.op == op_write) && !mem_done);

   assign npc = load_pc ? {{(`TC_PC_W-`TC_NEXT_W){1'b0}}, uword.next} : pc + 1'b1;
   assign next_pc = stall ? pc : npc;   // stores refetch current word

   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= '1;
      else if (!stall)
         pc <= npc;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         wait_count <= '0;
      else if (uword.op != op_wait || !stall)
         wait_count <= '0;
      else if (start)
         wait_count <= wait_count + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         a <= '0;
         b <= '0;
         c <= '0;
         d <= '0;
      end
      else
      begin
         if (!stall && (uword.op == op_add || uword.op == op_sub))
            case (uword.dst)
               sel_a:   a <= alu_out;
               sel_b:   b <= alu_out;
               sel_c:   c <= alu_out;
               sel_d:   d <= alu_out;
               default: ;
            endcase
         if (memdone)
            d <= rdata;   // read data wins
      end
   end

   assign addr  = a[`TC_ADDR_W-1:0];
   assign wdata = d;

   always_comb
   begin
      cmd.rd = uword.op == op_read;
      cmd.wr = uword.op == op_write;
   end

   assign done  = uword.op == op_done;
   assign fault = uword.op == op_fault;

endmodule

`default_nettype wire

//--- src/test_cpu_top.sv
////////////////////////////////////////////////////////////
// test cpu top level
// microcode and pattern stores, sequencer and bus requester
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "test_cpu_consts.svh"

module test_cpu_top
(
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   start,
   input  wire                   memack,
   input  wire                   memdone,
   input  wire [`TC_DATA_W-1:0]  rdata,
   output wire                   memrq,
   output wire                   memwr,
   output wire [`TC_ADDR_W-1:0]  addr,
   output wire [`TC_DATA_W-1:0]  wdata,
   output wire                   done,
   output wire                   fault
);

   import test_cpu_pkg::*;

   uword_t                uword;
   bus_cmd_t              cmd;
   logic [`TC_PC_W-1:0]   next_pc;
   logic [`TC_DATA_W-1:0] expected;
   logic                  mem_done;

   ucode_rom ucode_rom_inst (
      .clk   (clk),
      .reset (reset),
      .addr  (next_pc),
      .uword (uword)
   );

   pattern_rom pattern_rom_inst (
      .clk      (clk),
      .reset    (reset),
      .index    (addr[`TC_PAT_W-1:0]),   // buffer slot from register a
      .expected (expected)
   );

   ucode_sequencer ucode_sequencer_inst (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .uword    (uword),
      .expected (expected),
      .mem_done (mem_done),
      .memdone  (memdone),
      .rdata    (rdata),
      .next_pc  (next_pc),
      .addr     (addr),
      .wdata    (wdata),
      .cmd      (cmd),
      .done     (done),
      .fault    (fault)
   );

   bus_requester bus_requester_inst (
      .clk      (clk),
      .reset    (reset),
      .cmd      (cmd),
      .memack   (memack),
      .memrq    (memrq),
      .memwr    (memwr),
      .mem_done (mem_done)
   );

endmodule

`default_nettype wire

//--- verif/tb_test_cpu.sv
////////////////////////////////////////////////////////////
// test cpu testbench
// bus slave model with buffer memory and status register,
// clean run and corrupted-word run checked against the model
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "test_cpu_consts.svh"

module tb_test_cpu;

   localparam int clk_period  = 100;
   localparam int run_clocks  = 530 * 16 + 10 * 256 + 5 * 32 + 100;   // bus ops, plain ops, waits
   localparam int watch_limit = 20 + 2 * (run_clocks + 10) + 200;

   localparam logic [`TC_ADDR_W-1:0] buf_base    = 22'h11000;
   localparam logic [`TC_ADDR_W-1:0] status_addr = 22'o17377770;
   localparam logic [`TC_ADDR_W-1:0] go_addr     = 22'o17377777;

   logic                  clk;
   logic                  reset;
   logic                  start;
   logic                  memack;
   logic                  memdone;
   logic [`TC_DATA_W-1:0] rdata;
   logic                  memrq;
   logic                  memwr;
   logic [`TC_ADDR_W-1:0] addr;
   logic [`TC_DATA_W-1:0] wdata;
   logic                  done;
   logic                  fault;

   logic [31:0]           lcg_state = 32'd54;
   logic [`TC_DATA_W-1:0] buf_mem [0:255];
   logic [`TC_ADDR_W-1:0] dev_addr  [0:3] = '{22'o17377776, 22'o17377775, 22'o17377774, go_addr};
   logic [`TC_DATA_W-1:0] dev_value [0:3] = '{32'h0001_1000, 32'h0001_0100, 32'o11, 32'h0};
   int                    error_count [0:5];
   int                    write_index;
   int                    read_index;
   int                    dev_step;
   int                    polls_left;
   int                    corrupt_index;
   int                    failed;
   logic                  status_busy;
   logic                  poll_pending;   // last status read returned busy
   logic                  corrupt_run;

   test_cpu_top test_cpu_top_inst (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .memack  (memack),
      .memdone (memdone),
      .rdata   (rdata),
      .memrq   (memrq),
      .memwr   (memwr),
      .addr    (addr),
      .wdata   (wdata),
      .done    (done),
      .fault   (fault)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   function automatic int next_random(input int range);
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return int'((lcg_state >> 16) % range);
   endfunction

   // buffer word i: i in every byte, upper half inverted
   function automatic logic [`TC_DATA_W-1:0] expected_pattern(input int i);
      logic [`TC_DATA_W-1:0] w;
      w = i * 32'h0101_0101;
      return w ^ 32'hffff_0000;
   endfunction

   task automatic count_error(input int t);
      error_count[corrupt_run ? 5 : t]++;   // second run owns all its errors
   endtask

   task automatic expect_low(input string name, input logic value);
      if (value !== 1'b0)
      begin
         $display("** Error %s expected 0 actual %h", name, value);
         count_error(0);
      end
   endtask

   task automatic handle_write(input logic [`TC_ADDR_W-1:0] a, input logic [`TC_DATA_W-1:0] d);
      int idx;
      idx = int'(a) - int'(buf_base);
      if (idx >= 0 && idx < 256)
      begin
         if (idx != write_index)
         begin
            $display("buffer write to word %0d, expected word %0d", idx, write_index);
            count_error(1);
         end
         if (d !== expected_pattern(idx))
         begin
            $display("** Error wdata word %0d expected %h actual %h", idx,
                     expected_pattern(idx), d);
            count_error(1);
         end
         buf_mem[idx] = d;
         write_index++;
      end
      else if (a == status_addr)
      begin
         $display("write reached the status address");
         count_error(2);
      end
      else if (dev_step < 4 && a == dev_addr[dev_step])
      begin
         if (d !== dev_value[dev_step])
         begin
            $display("** Error wdata register %o expected %h actual %h", a,
                     dev_value[dev_step], d);
            count_error(2);
         end
         dev_step++;
         if (a == go_addr)
         begin
            status_busy = 1'b1;
            polls_left = 1 + next_random(4);
            if (corrupt_run)
               buf_mem[corrupt_index] ^= 32'h1 << next_random(32);
         end
      end
      else
      begin
         $display("unexpected write to address %h at device step %0d", a, dev_step);
         count_error(2);
      end
   endtask

   task automatic handle_read(input logic [`TC_ADDR_W-1:0] a, output logic [`TC_DATA_W-1:0] d);
      int idx;
      idx = int'(a) - int'(buf_base);
      d = '0;
      if (a == status_addr)
      begin
         if (dev_step < 4)
         begin
            $display("status read before the go write");
            count_error(3);
         end
         d = {31'b0, status_busy};
         poll_pending = status_busy;
         if (status_busy)
         begin
            polls_left--;
            if (polls_left == 0)
               status_busy = 1'b0;
         end
      end
      else if (idx >= 0 && idx < 256)
      begin
         if (status_busy || dev_step < 4)
         begin
            $display("buffer read while the device was still busy");
            count_error(3);
         end
         if (idx != read_index)
         begin
            $display("buffer read of word %0d, expected word %0d", idx, read_index);
            count_error(4);
         end
         if (corrupt_run && idx > corrupt_index)
         begin
            $display("buffer read of word %0d past corrupted word %0d", idx, corrupt_index);
            count_error(5);
         end
         d = buf_mem[idx];
         read_index++;
      end
      else
      begin
         $display("unexpected read of address %h", a);
         count_error(4);
      end
   endtask

   initial
   begin : slave_model
      logic [`TC_ADDR_W-1:0] acc_addr;
      logic [`TC_DATA_W-1:0] acc_wdata;
      logic [`TC_DATA_W-1:0] acc_rdata;
      logic                  acc_wr;
      int                    ack_delay;
      int                    done_delay;
      forever
      begin
         @(negedge clk);
         if (!reset && memrq)
         begin
            acc_addr  = addr;
            acc_wr    = memwr;
            acc_wdata = wdata;
            ack_delay  = next_random(8);
            done_delay = next_random(4);
            if (poll_pending && (acc_wr || acc_addr != status_addr))
            begin
               $display("bus access other than a status poll while busy");
               count_error(3);
            end
            poll_pending = 1'b0;
            repeat (ack_delay) @(negedge clk);
            memack = 1'b1;
            if (acc_wr)
               handle_write(acc_addr, acc_wdata);
            else
               handle_read(acc_addr, acc_rdata);
            repeat (done_delay) @(negedge clk);
            if (!acc_wr)
            begin
               rdata   = acc_rdata;
               memdone = 1'b1;
            end
            @(negedge clk);
            memdone = 1'b0;
            memack  = 1'b0;   // memdone already seen
         end
      end
   end

   task automatic apply_reset();
      @(negedge clk);
      reset = 1'b1;
      start = 1'b0;
      write_index  = 0;
      read_index   = 0;
      dev_step     = 0;
      polls_left   = 0;
      status_busy  = 1'b0;
      poll_pending = 1'b0;
      repeat (5) @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic run_program();
      start = 1'b1;
      do
         @(negedge clk);
      while (!(done || fault));
   endtask

   task automatic report_test(input int t, input string name);
      $display("test %0d %s: %s (%0d errors)", t, name,
               error_count[t] == 0 ? "PASS" : "FAIL", error_count[t]);
   endtask

   initial
   begin
      reset   = 1'b1;
      start   = 1'b0;
      memack  = 1'b0;
      memdone = 1'b0;
      rdata   = '0;
      corrupt_run   = 1'b0;
      corrupt_index = -1;
      failed        = 0;
      for (int t = 0; t < 6; t++)
         error_count[t] = 0;

      apply_reset();
      repeat (20)
      begin
         @(negedge clk);
         expect_low("memrq", memrq);
         expect_low("memwr", memwr);
         expect_low("done", done);
         expect_low("fault", fault);
      end
      report_test(0, "reset_idle");

      run_program();
      if (write_index != 256)
      begin
         $display("only %0d buffer words written", write_index);
         count_error(1);
      end
      if (dev_step != 4)
      begin
         $display("only %0d device registers written", dev_step);
         count_error(2);
      end
      if (done !== 1'b1 || fault !== 1'b0)
      begin
         $display("** Error done/fault expected 1/0 actual %h/%h", done, fault);
         count_error(4);
      end
      if (read_index != 256)
      begin
         $display("only %0d buffer words read back", read_index);
         count_error(4);
      end
      report_test(1, "buffer_fill");
      report_test(2, "device_regs");
      report_test(3, "status_poll");
      report_test(4, "clean_readback");

      apply_reset();
      corrupt_run   = 1'b1;
      corrupt_index = next_random(256);
      run_program();
      if (fault !== 1'b1 || done !== 1'b0)
      begin
         $display("** Error fault/done expected 1/0 actual %h/%h", fault, done);
         count_error(5);
      end
      if (read_index != corrupt_index + 1)
      begin
         $display("%0d buffer words read, corrupted word was %0d", read_index, corrupt_index);
         count_error(5);
      end
      report_test(5, "corrupt_readback");

      for (int t = 0; t < 6; t++)
         if (error_count[t] != 0)
            failed++;
      $display("tests run: 6, failed: %0d", failed);
      if (failed == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   initial
   begin : watchdog
      repeat (watch_limit) @(posedge clk);
      $display("watchdog expired after %0d cycles, program never halted", watch_limit);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
+incdir+src
src/test_cpu_pkg.sv
src/ucode_rom.sv
src/pattern_rom.sv
src/bus_requester.sv
src/ucode_sequencer.sv
src/test_cpu_top.sv
verif/tb_test_cpu.sv

//--- Bender.yml
package:
  name: test_cpu

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/test_cpu_pkg.sv
      - src/ucode_rom.sv
      - src/pattern_rom.sv
      - src/bus_requester.sv
      - src/ucode_sequencer.sv
      - src/test_cpu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/tb_test_cpu.sv
